/* rtl/mips_config.svh */
// Sizes and memory map for core and bench; every access is a full word and RAM sits below GPIO
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_DATA_WIDTH      32            // Machine word
`define MIPS_REG_ADDR_WIDTH  5             // 32 architectural registers

`define MIPS_ROM_ADDR_WIDTH  6             // 64 program words
`define MIPS_RAM_ADDR_WIDTH  6             // 64 data words

`define MIPS_BOOT_ADDR       32'h0040_0000 // First fetch after reset, ROM word 0
`define MIPS_RAM_BASE        32'h0000_1000 // RAM word 0
`define MIPS_GPIO_ADDR       32'h0000_2000 // Single store-only GPIO register

`define MIPS_GPIO_WIDTH      8             // Low byte of the stored word

`endif

/* rtl/mips_pkg.sv */
// Types for the multicycle core; enum values follow the standard MIPS-I encodings
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    typedef logic [`MIPS_DATA_WIDTH-1:0]     word_t;      // Data and addresses
    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;  // rs, rt, rd
    typedef logic [`MIPS_ROM_ADDR_WIDTH-1:0] rom_addr_t;  // Program word index
    typedef logic [`MIPS_GPIO_WIDTH-1:0]     gpio_t;      // GPIO output byte

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,   // add, sub, and, or, slt
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a      // Signed compare
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_MEM_ADDR,
        S_MEM_READ,
        S_MEM_WRITEBACK,
        S_MEM_WRITE,
        S_EXECUTE,
        S_ALU_WRITEBACK,
        S_ADDI_EXECUTE,
        S_ADDI_WRITEBACK,
        S_BRANCH,
        S_JUMP
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/mips_alu.sv */
// Purely combinational ALU with no overflow trap, and slt compares as signed two's complement
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  word_t   a,          // PC or register A
    input  word_t   b,          // B, 4, immediate or shifted immediate
    input  alu_op_t op,
    output word_t   result,
    output logic    zero        // Used by beq after a subtract
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            default: result = '0;       // Unused encodings
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/mips_regfile.sv */
// Register file with reads that are not registered; register zero is never written
`default_nettype none

`include "mips_config.svh"

module mips_regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra1,      // rs
    input  reg_addr_t ra2,      // rt
    input  reg_addr_t wa,       // rt or rd
    input  word_t     wd,
    input  logic      we,
    output word_t     rd1,
    output word_t     rd2
);

    localparam int num_regs = 1 << `MIPS_REG_ADDR_WIDTH;

    word_t regs [0:num_regs-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;                  // All registers start at zero
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;                     // $zero stays hardwired
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

`default_nettype wire

/* rtl/mips_control.sv */
// Moore FSM with a fixed step count per instruction, so nothing can stall it
`default_nettype none

module mips_control import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  opcode_t     opcode,     // From the instruction register
    input  funct_t      funct,
    input  logic        zero,       // ALU compare result
    output logic        pc_write,   // Unconditional PC update
    output logic        branch,     // Taken beq, already qualified by zero
    output logic        iord,       // 0 fetch from PC, 1 data from ALUOut
    output logic        mem_write,
    output logic        ir_write,
    output logic        mdr_write,
    output logic        reg_write,
    output logic        reg_dst,    // 0 rt, 1 rd
    output logic        mem_to_reg, // 0 ALUOut, 1 MDR
    output logic        alu_src_a,  // 0 PC, 1 A
    output logic [1:0]  alu_src_b,  // B, 4, imm, imm << 2
    output logic [1:0]  pc_src,     // ALU result, ALUOut, jump target
    output alu_op_t     alu_op
);

    ctrl_state_t state, state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = S_FETCH;                       // Every sequence ends back at fetch
        case (state)
            S_FETCH:  state_next = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_RTYPE:     state_next = S_EXECUTE;
                    OP_ADDI:      state_next = S_ADDI_EXECUTE;
                    OP_LW, OP_SW: state_next = S_MEM_ADDR;
                    OP_BEQ:       state_next = S_BRANCH;
                    OP_J:         state_next = S_JUMP;
                    default:      state_next = S_FETCH;  // Treated as a nop
                endcase
            end
            S_MEM_ADDR:     state_next = (opcode == OP_LW) ? S_MEM_READ : S_MEM_WRITE;
            S_MEM_READ:     state_next = S_MEM_WRITEBACK;
            S_EXECUTE:      state_next = S_ALU_WRITEBACK;
            S_ADDI_EXECUTE: state_next = S_ADDI_WRITEBACK;
            default:        state_next = S_FETCH;
        endcase
    end

    always_comb begin
        pc_write   = 1'b0;
        branch     = 1'b0;
        iord       = 1'b0;
        mem_write  = 1'b0;
        ir_write   = 1'b0;
        mdr_write  = 1'b0;
        reg_write  = 1'b0;
        reg_dst    = 1'b0;
        mem_to_reg = 1'b0;
        alu_src_a  = 1'b0;
        alu_src_b  = 2'b00;
        pc_src     = 2'b00;
        alu_op     = ALU_ADD;
        case (state)
            S_FETCH: begin
                ir_write  = 1'b1;                   // Latch instruction at PC
                pc_write  = 1'b1;                   // PC <= PC + 4
                alu_src_b = 2'b01;
            end
            S_DECODE: begin
                alu_src_b = 2'b11;                  // Branch target into ALUOut
            end
            S_MEM_ADDR, S_ADDI_EXECUTE: begin
                alu_src_a = 1'b1;                   // A + sign-extended imm
                alu_src_b = 2'b10;
            end
            S_MEM_READ: begin
                iord      = 1'b1;
                mdr_write = 1'b1;
            end
            S_MEM_WRITEBACK: begin
                reg_write  = 1'b1;                  // rt <= MDR
                mem_to_reg = 1'b1;
            end
            S_MEM_WRITE: begin
                iord      = 1'b1;
                mem_write = 1'b1;                   // Store B
            end
            S_EXECUTE: begin
                alu_src_a = 1'b1;
                case (funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;      // add and unknown functs
                endcase
            end
            S_ALU_WRITEBACK: begin
                reg_write = 1'b1;                   // rd <= ALUOut
                reg_dst   = 1'b1;
            end
            S_ADDI_WRITEBACK: begin
                reg_write = 1'b1;                   // rt <= ALUOut
            end
            S_BRANCH: begin
                alu_src_a = 1'b1;
                alu_op    = ALU_SUB;                // A - B, equal gives zero
                branch    = zero;                   // Forms the PC enable
                pc_src    = 2'b01;
            end
            S_JUMP: begin
                pc_write = 1'b1;
                pc_src   = 2'b10;
            end
            default: ;
        endcase
    end

    // The datapath must present a decodable instruction when the FSM dispatches on it
    a_known_opcode: assert property (@(posedge clk) disable iff (reset)
        state == S_DECODE |-> opcode inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_J})
        else $error("Unsupported opcode %0h at decode", opcode);

endmodule

`default_nettype wire

/* rtl/mips_datapath.sv */
// Datapath for the multicycle core; A, B, ALUOut and MDR reload whenever their step comes
`default_nettype none

`include "mips_config.svh"

module mips_datapath import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        pc_write,
    input  logic        branch,
    input  logic        iord,
    input  logic        ir_write,
    input  logic        mdr_write,
    input  logic        reg_write,
    input  logic        reg_dst,
    input  logic        mem_to_reg,
    input  logic        alu_src_a,
    input  logic [1:0]  alu_src_b,
    input  logic [1:0]  pc_src,
    input  alu_op_t     alu_op,
    input  word_t       mem_rdata,
    output opcode_t     opcode,
    output funct_t      funct,
    output logic        zero,
    output word_t       mem_addr,
    output word_t       mem_wdata
);

    word_t     pc;              // Program counter
    word_t     instr;           // Instruction register
    word_t     mdr;             // Memory data register
    word_t     reg_a;
    word_t     reg_b;
    word_t     alu_out;
    word_t     rd1;
    word_t     rd2;
    word_t     src_a;
    word_t     src_b;
    word_t     alu_result;
    word_t     sign_imm;
    word_t     branch_off;
    word_t     jump_addr;
    word_t     pc_next;
    word_t     wd;
    reg_addr_t wa;
    logic      pc_en;

    assign pc_en = pc_write | branch;       // branch is only high when taken

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `MIPS_BOOT_ADDR;
            instr <= '0;
        end else begin
            if (pc_en) begin
                pc <= pc_next;
            end
            if (ir_write) begin
                instr <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        reg_a   <= rd1;                     // Operands follow the current IR
        reg_b   <= rd2;
        alu_out <= alu_result;
        if (mdr_write) begin
            mdr <= mem_rdata;
        end
    end

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    assign sign_imm   = {{16{instr[15]}}, instr[15:0]};
    assign branch_off = {sign_imm[`MIPS_DATA_WIDTH-3:0], 2'b00};    // Word offset to bytes
    assign jump_addr  = {pc[31:28], instr[25:0], 2'b00};           // Region of PC + 4

    assign wa = reg_dst ? instr[15:11] : instr[20:16];
    assign wd = mem_to_reg ? mdr : alu_out;

    mips_regfile regfile_i (
        .clk   (clk),
        .reset (reset),
        .ra1   (instr[25:21]),
        .ra2   (instr[20:16]),
        .wa    (wa),
        .wd    (wd),
        .we    (reg_write),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign src_a = alu_src_a ? reg_a : pc;

    always_comb begin
        case (alu_src_b)
            2'b00:   src_b = reg_b;
            2'b01:   src_b = word_t'(4);            // Sequential fetch
            2'b10:   src_b = sign_imm;
            default: src_b = branch_off;
        endcase
    end

    mips_alu alu_i (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    always_comb begin
        case (pc_src)
            2'b00:   pc_next = alu_result;          // PC + 4 in fetch
            2'b01:   pc_next = alu_out;             // Target computed in decode
            default: pc_next = jump_addr;
        endcase
    end

    assign mem_addr  = iord ? alu_out : pc;
    assign mem_wdata = reg_b;

    // Data accesses come from base plus offset, which the program must keep aligned
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        iord |-> mem_addr[1:0] == 2'b00)
        else $error("Unaligned data address %h", mem_addr);

endmodule

`default_nettype wire

/* rtl/mips_memory_map.sv */
// ROM index wraps every 64 words above boot, the ROM loads only during reset, GPIO is write-only
`default_nettype none

`include "mips_config.svh"

module mips_memory_map import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     mem_addr,     // Byte address from the datapath
    input  word_t     mem_wdata,
    input  logic      mem_write,
    input  logic      load_en,      // ROM fill port
    input  rom_addr_t load_addr,
    input  word_t     load_data,
    output word_t     mem_rdata,
    output gpio_t     gpio_data,
    output logic      gpio_valid    // One cycle after each GPIO store
);

    localparam word_t ram_end = `MIPS_RAM_BASE + (4 << `MIPS_RAM_ADDR_WIDTH);

    word_t rom [0:(1 << `MIPS_ROM_ADDR_WIDTH)-1];
    word_t ram [0:(1 << `MIPS_RAM_ADDR_WIDTH)-1];

    word_t                           rom_off;
    word_t                           ram_off;
    rom_addr_t                       rom_idx;
    logic [`MIPS_RAM_ADDR_WIDTH-1:0] ram_idx;
    logic                            in_rom;
    logic                            in_ram;
    logic                            is_gpio;

    assign rom_off = mem_addr - `MIPS_BOOT_ADDR;
    assign ram_off = mem_addr - `MIPS_RAM_BASE;
    assign rom_idx = rom_off[`MIPS_ROM_ADDR_WIDTH+1:2];     // Byte to word index
    assign ram_idx = ram_off[`MIPS_RAM_ADDR_WIDTH+1:2];

    assign in_rom  = (mem_addr >= `MIPS_BOOT_ADDR);
    assign in_ram  = (mem_addr >= `MIPS_RAM_BASE) && (mem_addr < ram_end);
    assign is_gpio = (mem_addr == `MIPS_GPIO_ADDR);

    always_comb begin
        if (in_rom) begin
            mem_rdata = rom[rom_idx];
        end else if (in_ram) begin
            mem_rdata = ram[ram_idx];
        end else begin
            mem_rdata = '0;                 // Holes and GPIO read as zero
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            rom[load_addr] <= load_data;
        end
        if (mem_write && in_ram) begin
            ram[ram_idx] <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_data  <= '0;
            gpio_valid <= 1'b0;
        end else begin
            gpio_valid <= mem_write && is_gpio;
            if (mem_write && is_gpio) begin
                gpio_data <= mem_wdata[`MIPS_GPIO_WIDTH-1:0];
            end
        end
    end

    // A ROM write while the core runs could change an instruction under fetch
    a_load_in_reset: assert property (@(posedge clk) load_en |-> reset)
        else $error("ROM load outside reset at word %0d", load_addr);

endmodule

`default_nettype wire

/* rtl/mips_top.sv */
// Core top with the ROM filled through the load port while reset is held
`default_nettype none

module mips_top import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      load_en,
    input  rom_addr_t load_addr,
    input  word_t     load_data,
    output gpio_t     gpio_data,
    output logic      gpio_valid
);

    logic        pc_write;
    logic        branch;
    logic        iord;
    logic        mem_write;
    logic        ir_write;
    logic        mdr_write;
    logic        reg_write;
    logic        reg_dst;
    logic        mem_to_reg;
    logic        alu_src_a;
    logic [1:0]  alu_src_b;
    logic [1:0]  pc_src;
    alu_op_t     alu_op;
    opcode_t     opcode;
    funct_t      funct;
    logic        zero;
    word_t       mem_addr;
    word_t       mem_wdata;
    word_t       mem_rdata;

    mips_control control_i (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .zero       (zero),
        .pc_write   (pc_write),
        .branch     (branch),
        .iord       (iord),
        .mem_write  (mem_write),
        .ir_write   (ir_write),
        .mdr_write  (mdr_write),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .mem_to_reg (mem_to_reg),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .pc_src     (pc_src),
        .alu_op     (alu_op)
    );

    mips_datapath datapath_i (
        .clk        (clk),
        .reset      (reset),
        .pc_write   (pc_write),
        .branch     (branch),
        .iord       (iord),
        .ir_write   (ir_write),
        .mdr_write  (mdr_write),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .mem_to_reg (mem_to_reg),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .pc_src     (pc_src),
        .alu_op     (alu_op),
        .mem_rdata  (mem_rdata),
        .opcode     (opcode),
        .funct      (funct),
        .zero       (zero),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    mips_memory_map memory_map_i (
        .clk        (clk),
        .reset      (reset),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_write  (mem_write),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .mem_rdata  (mem_rdata),
        .gpio_data  (gpio_data),
        .gpio_valid (gpio_valid)
    );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
// Bench clock at 8 ns, reset stays high while hold is set and for four rising edges after it drops
`default_nettype none

module clock_gen (
    input  logic hold,      // Keeps reset high, used over the ROM load
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        @(posedge clk);
        while (hold) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);              // Four edges in reset after the hold
        #1 reset = 1'b0;                        // Same skew as the other inputs
    end

endmodule

`default_nettype wire

/* sim/mips_tb.sv */
// Random forward-only programs; every lw reads a RAM word stored earlier, so RAM needs no init
`default_nettype none

`include "mips_config.svh"

module mips_tb import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int        clk_period_ns = 8;
    localparam int        rom_words     = 1 << `MIPS_ROM_ADDR_WIDTH;
    localparam int        ram_words     = 1 << `MIPS_RAM_ADDR_WIDTH;
    localparam int        max_prog      = 60;           // Final self jump included
    localparam int        quiet_cycles  = 50;
    localparam reg_addr_t zero_reg      = '0;
    localparam logic [15:0] gpio_off    = 16'(`MIPS_GPIO_ADDR);

    logic      clk;
    logic      reset;
    logic      hold;                // Stretches reset over the ROM load
    logic      load_en;
    rom_addr_t load_addr;
    word_t     load_data;
    gpio_t     gpio_data;
    logic      gpio_valid;

    integer    seed = 58896;
    word_t     prog [0:rom_words-1];
    int        prog_len;
    gpio_t     exp_vals [$];        // GPIO bytes in model order
    string     exp_names [$];       // Instruction that produced each byte
    gpio_t     exp_byte;
    string     exp_name;
    logic      prog_ready;
    logic      armed;               // Output checks start after the first edge
    logic      seen_event;
    longint    limit_ns;

    clock_gen clock_gen_i (.hold(hold), .clk(clk), .reset(reset));

    mips_top mips_top_i (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .gpio_data  (gpio_data),
        .gpio_valid (gpio_valid)
    );

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string test, gpio_t expected, gpio_t actual);
        fail_run($sformatf("Fail %s: expected %02h, actual %02h", test, expected, actual));
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_j(int idx);
        word_t target;
        target = `MIPS_BOOT_ADDR + word_t'(4 * idx);
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [15:0] ram_off(int k);
        return 16'(`MIPS_RAM_BASE + 4 * k);             // Offset from $zero
    endfunction

    task automatic emit(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic gen_program();
        int         kind;
        int         k;
        int         written [$];
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [5:0] fn;
        prog_len = 0;
        while (prog_len <= max_prog - 4) begin          // Room for a three-word block
            kind = rand_below(10);
            rs   = reg_addr_t'(rand_below(8));          // Few registers, many collisions
            rt   = reg_addr_t'(rand_below(8));
            rd   = reg_addr_t'(rand_below(8));
            if (kind < 3) begin
                emit(enc_i(OP_ADDI, rs, rt, 16'($random(seed))));
                emit(enc_i(OP_SW, zero_reg, rt, gpio_off));
            end else if (kind < 6) begin
                case (rand_below(5))
                    0:       fn = FN_ADD;
                    1:       fn = FN_SUB;
                    2:       fn = FN_AND;
                    3:       fn = FN_OR;
                    default: fn = FN_SLT;
                endcase
                emit(enc_r(rs, rt, rd, fn));
                emit(enc_i(OP_SW, zero_reg, rd, gpio_off));
            end else if (kind == 6) begin
                k = rand_below(ram_words);
                written.push_back(k);
                emit(enc_i(OP_SW, zero_reg, rt, ram_off(k)));
                k = written[rand_below(written.size())];   // Any word stored so far
                emit(enc_i(OP_LW, zero_reg, rd, ram_off(k)));
                emit(enc_i(OP_SW, zero_reg, rd, gpio_off));
            end else if (kind < 9) begin
                if (rand_below(3) == 0) begin
                    rt = rs;                            // Bias toward taken
                end
                emit(enc_i(OP_BEQ, rs, rt, 16'd2));     // Skips the next pair
                emit(enc_i(OP_ADDI, rs, rd, 16'($random(seed))));
                emit(enc_i(OP_SW, zero_reg, rd, gpio_off));
            end else begin
                emit(enc_j(prog_len + 2));              // Over one GPIO store
                emit(enc_i(OP_SW, zero_reg, rt, gpio_off));
            end
        end
        emit(enc_j(prog_len));                          // Park on itself
    endtask

    task automatic run_model();
        word_t regs [0:31];
        word_t ram [0:ram_words-1];
        word_t w;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t jt;
        int    pc;
        int    pc_next;
        int    steps;
        logic  done;
        string last;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        last  = "none";
        while (!done && steps < 4 * max_prog) begin
            w       = prog[pc];
            a       = regs[w[25:21]];
            b       = regs[w[20:16]];
            addr    = a + {{16{w[15]}}, w[15:0]};   // rs + sign-extended imm
            pc_next = pc + 1;
            case (w[31:26])
                OP_RTYPE: begin
                    case (w[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    last = (w[5:0] == FN_SLT) ? "rtype slt" : "rtype";
                    if (w[15:11] != 5'd0) begin
                        regs[w[15:11]] = res;
                    end
                end
                OP_ADDI: begin
                    last = "addi";
                    if (w[20:16] != 5'd0) begin
                        regs[w[20:16]] = addr;
                    end
                end
                OP_LW: begin
                    last = "lw";
                    if (w[20:16] != 5'd0) begin
                        regs[w[20:16]] = ram[int'((addr - `MIPS_RAM_BASE) >> 2)];
                    end
                end
                OP_SW: begin
                    if (addr == `MIPS_GPIO_ADDR) begin
                        exp_vals.push_back(b[`MIPS_GPIO_WIDTH-1:0]);
                        exp_names.push_back(last);
                    end else begin
                        ram[int'((addr - `MIPS_RAM_BASE) >> 2)] = b;
                    end
                end
                OP_BEQ: begin
                    if (a == b) begin
                        pc_next = pc + 1 + int'($signed(w[15:0]));
                    end
                end
                OP_J: begin
                    jt      = `MIPS_BOOT_ADDR + word_t'(4 * (pc + 1));
                    jt      = {jt[31:28], w[25:0], 2'b00};
                    pc_next = int'((jt - `MIPS_BOOT_ADDR) >> 2);
                    done    = (pc_next == pc);
                end
                default: fail_run("Model met an instruction outside the supported set");
            endcase
            pc = pc_next;
            steps++;
        end
        assert (done) else fail_run("Model never reached the final jump");
    endtask

    initial begin
        hold       = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        prog_ready = 1'b0;
        armed      = 1'b0;
        seen_event = 1'b0;
        gen_program();
        run_model();
        prog_ready = 1'b1;
        @(posedge clk);
        armed = 1'b1;
        for (int i = 0; i < rom_words; i++) begin
            #1;
            load_en   = 1'b1;
            load_addr = rom_addr_t'(i);
            load_data = (i < prog_len) ? prog[i] : '0;
            @(posedge clk);
        end
        #1;
        load_en = 1'b0;
        hold    = 1'b0;                                 // Reset follows four edges later
        while (exp_vals.size() != 0) begin
            @(negedge clk);
        end
        repeat (quiet_cycles) begin
            @(negedge clk);
            assert (!gpio_valid) else fail_run("GPIO event after the last expected one");
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // Outputs are sampled on the falling edge, half a period from any change
    always @(negedge clk) begin
        if (armed) begin
            if (reset) begin
                assert (!gpio_valid && gpio_data == '0)
                    else fail_run("GPIO output not idle while reset is high");
            end else if (gpio_valid) begin
                assert (exp_vals.size() != 0)
                    else fail_run("GPIO event after the last expected one");
                exp_byte   = exp_vals.pop_front();
                exp_name   = exp_names.pop_front();
                seen_event = 1'b1;
                assert (gpio_data == exp_byte)
                    else report_mismatch(exp_name, exp_byte, gpio_data);
            end else if (!seen_event) begin
                assert (gpio_data == '0)
                    else fail_run("GPIO data changed before the first GPIO store");
            end
        end
    end

    initial begin
        wait (prog_ready);
        limit_ns = longint'(prog_len) * 5 * clk_period_ns * 2       // Slowest instruction
                 + longint'(rom_words + 5) * clk_period_ns           // Load and reset
                 + longint'(quiet_cycles) * clk_period_ns;
        #(limit_ns);
        fail_run($sformatf("Timeout, program did not finish with %0d GPIO events missing",
                           exp_vals.size()));
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_regfile.sv
rtl/mips_control.sv
rtl/mips_datapath.sv
rtl/mips_memory_map.sv
rtl/mips_top.sv
sim/clock_gen.sv
sim/mips_tb.sv

/* Makefile */
OBJ_DIR := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/100ps --top-module mips_tb -f src.f -Mdir $(OBJ_DIR)

run: compile
	out=$$(./$(OBJ_DIR)/Vmips_tb); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf $(OBJ_DIR)
